/* design/discrete_pkg.sv */
// discrete sound package.
// shared sample and logarithm types, fixed-point constants and counter
// widths for the 555 astable oscillator datapath.
`default_nettype none

package discrete_pkg;

    // signed audio or control-voltage sample.
    typedef logic signed [15:0] sample_t;

    // natural log result, 8 fraction bits.
    typedef logic [11:0] ln_t;

    // log argument, 8 fraction bits, always >= 1.0.
    typedef logic [23:0] log_in_t;

    // oscillator cycle counter.
    typedef logic [63:0] cycle_count_t;

    // fixed-point formats.
    localparam int unsigned LN_FRAC_BITS   = 8;                  // log in/out fraction.
    localparam int unsigned LOG_ONE        = 1 << LN_FRAC_BITS;  // 1.0 as log argument.
    localparam int unsigned LOG_TABLE_BITS = 6;                  // mantissa bits into table.
    localparam int unsigned LN2_FRAC_BITS  = 16;
    localparam int unsigned C_FRAC_BITS    = 35;                 // capacitance scaling.

    // ln 2 at two scalings.
    localparam int unsigned LN2_16_SHIFTED = 45426;
    localparam int unsigned LN2_8_SHIFTED  =
        LN2_16_SHIFTED >> (LN2_FRAC_BITS - LN_FRAC_BITS);    // 177.

    // supply level, also the upper bound for the control voltage.
    localparam sample_t VCC_LEVEL = 16'sd32767;

    // square wave output levels.
    localparam sample_t HIGH_LEVEL = '1;  // all ones.
    localparam sample_t LOW_LEVEL  = '0;

    // dropped sample counter width on the output side.
    localparam int unsigned DROP_COUNT_W = 16;

endpackage

`default_nettype wire

/* design/natural_log.sv */
// natural logarithm, two stage pipeline.
// input and output carry 8 fraction bits; the input must be >= 1.0.
// stage one finds the leading one and normalizes the mantissa,
// stage two sums exponent * ln 2, a table entry and a linear residual.
`default_nettype none

module natural_log (
    input  logic                  clk,
    input  logic                  rst,
    input  discrete_pkg::log_in_t in_8_shifted,
    output discrete_pkg::ln_t     out_8_shifted
);
    import discrete_pkg::*;

    localparam int MSB     = $bits(log_in_t) - 1;
    localparam int POS_W   = $clog2($bits(log_in_t));
    localparam int EXP_W   = $clog2($bits(log_in_t) - LN_FRAC_BITS);
    localparam int RES_W   = LN_FRAC_BITS - LOG_TABLE_BITS;  // bits just below the index.
    localparam int RES_LSB = MSB - LN_FRAC_BITS;             // weight of one output lsb.

    // ln(1 + i/64) * 256, rounded.
    localparam logic [7:0] LN_TABLE [2**LOG_TABLE_BITS] = '{
        8'd0,   8'd4,   8'd8,   8'd12,  8'd16,  8'd19,  8'd23,  8'd27,
        8'd30,  8'd34,  8'd37,  8'd41,  8'd44,  8'd47,  8'd51,  8'd54,
        8'd57,  8'd60,  8'd63,  8'd67,  8'd70,  8'd73,  8'd76,  8'd79,
        8'd82,  8'd84,  8'd87,  8'd90,  8'd93,  8'd96,  8'd98,  8'd101,
        8'd104, 8'd106, 8'd109, 8'd112, 8'd114, 8'd117, 8'd119, 8'd122,
        8'd124, 8'd127, 8'd129, 8'd132, 8'd134, 8'd136, 8'd139, 8'd141,
        8'd143, 8'd146, 8'd148, 8'd150, 8'd152, 8'd154, 8'd157, 8'd159,
        8'd161, 8'd163, 8'd165, 8'd167, 8'd169, 8'd171, 8'd173, 8'd175
    };

    logic [POS_W-1:0]          lead_pos;  // position of the leading one.
    log_in_t                   norm;      // leading one moved to the msb.
    logic [EXP_W-1:0]          exp_q;
    logic [LOG_TABLE_BITS-1:0] idx_q;
    logic [RES_W-1:0]          res_q;

    // leading one search, higher bits win.
    always_comb begin
        lead_pos = POS_W'(LN_FRAC_BITS);  // 1.0 when nothing above is set.
        for (int i = LN_FRAC_BITS; i <= MSB; i++) begin
            if (in_8_shifted[i]) begin
                lead_pos = POS_W'(i);
            end
        end
        norm = in_8_shifted << (MSB - lead_pos);
    end

    // stage one.
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_q <= '0;
            idx_q <= '0;
            res_q <= '0;
        end else begin
            exp_q <= EXP_W'(lead_pos - POS_W'(LN_FRAC_BITS));  // integer part of log2.
            idx_q <= norm[MSB-1 -: LOG_TABLE_BITS];           // mantissa top bits.
            res_q <= norm[RES_LSB +: RES_W];                  // slope taken as one.
        end
    end

    // stage two.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_8_shifted <= '0;
        end else begin
            out_8_shifted <= ln_t'(exp_q * LN2_8_SHIFTED)
                           + ln_t'(LN_TABLE[idx_q])
                           + ln_t'(res_q);
        end
    end

    // the oscillator must never hand in an argument below one.
    assert property (@(posedge clk) disable iff (rst) in_8_shifted >= LOG_ONE)
        else $error("natural_log argument below 1.0: %0d", in_8_shifted);

endmodule

`default_nettype wire

/* design/cv_ingress.sv */
// control voltage input side.
// credit based receiver: incoming samples are registered, stored in a
// circular buffer and popped into the v_control register whenever the
// buffer holds one. each pop returns one credit to the source.
`default_nettype none

module cv_ingress #(
    parameter int unsigned CV_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cv_valid,
    input  discrete_pkg::sample_t cv_data,
    output logic                  cv_credit,
    output discrete_pkg::sample_t v_control
);
    import discrete_pkg::*;

    localparam int PTR_W = (CV_DEPTH > 1) ? $clog2(CV_DEPTH) : 1;
    localparam int CNT_W = $clog2(CV_DEPTH + 1);

    sample_t          mem [CV_DEPTH];
    logic             in_valid_q;  // registered source strobe.
    sample_t          in_data_q;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // entries held.
    logic             pop;

    assign pop = (count != '0);  // drain as soon as anything is there.

    // input register.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= cv_valid;
        end
    end

    always_ff @(posedge clk) begin
        in_data_q <= cv_data;
    end

    // buffer storage.
    always_ff @(posedge clk) begin
        if (in_valid_q) begin
            mem[wr_ptr] <= in_data_q;
        end
    end

    // pointers and fill level.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid_q) begin
                wr_ptr <= (wr_ptr == PTR_W'(CV_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CV_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid_q, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head register and credit return, same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            cv_credit <= 1'b0;
            v_control <= '0;  // zero volts.
        end else begin
            cv_credit <= pop;
            if (pop) begin
                v_control <= mem[rd_ptr];
            end
        end
    end

    // a write into a full buffer means the source sent without a credit.
    assert property (@(posedge clk) disable iff (rst)
        in_valid_q |-> (count != CNT_W'(CV_DEPTH)))
        else $error("cv_ingress write into full buffer, credit rule broken.");

endmodule

`default_nettype wire

/* design/astable_555_vco.sv */
// 555 timer as an astable voltage-controlled oscillator.
// high time  C*(R1+R2)*ln(1 + v/(2*(VCC-v))), from the control voltage.
// low time   C*R2*ln 2, fixed at elaboration.
// a wave counter compared against the high count gives a square wave,
// sampled on every audio clock enable.
`default_nettype none

module astable_555_vco #(
    parameter int unsigned CLOCK_RATE   = 50000000,
    parameter int unsigned R1           = 47000,
    parameter int unsigned R2           = 27000,
    parameter int unsigned C_35_SHIFTED = 1134  // 33 nF.
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  audio_clk_en,
    input  discrete_pkg::sample_t v_control,
    output logic                  sample_valid,
    output discrete_pkg::sample_t sample_data
);
    import discrete_pkg::*;

    localparam int unsigned LOW_FRAC_BITS = 27;
    localparam int unsigned HIGH_SHIFT    = C_FRAC_BITS + LN_FRAC_BITS;  // 43.

    // C*(R1+R2), 35 fraction bits.
    localparam cycle_count_t C_R1_R2_35_SHIFTED = cycle_count_t'(C_35_SHIFTED) * (R1 + R2);
    // C*R2*ln 2, brought down to 27 fraction bits.
    localparam cycle_count_t C_R2_LN2_27_SHIFTED =
        (cycle_count_t'(C_35_SHIFTED) * R2 * LN2_16_SHIFTED)
        >> (C_FRAC_BITS + LN2_FRAC_BITS - LOW_FRAC_BITS);
    localparam cycle_count_t CYCLES_LOW = (C_R2_LN2_27_SHIFTED * CLOCK_RATE) >> LOW_FRAC_BITS;

    sample_t      v_safe;            // clamped control voltage.
    log_in_t      log_num;
    log_in_t      log_den;
    log_in_t      to_log_8_shifted;  // 1 + v/(2*(VCC-v)).
    ln_t          ln_8_shifted;
    cycle_count_t cycles_high;
    cycle_count_t wave_length;
    cycle_count_t wave_counter;

    // clamp into 0..VCC-1 so the log argument stays >= 1 and finite.
    always_comb begin
        if (v_control < 0) begin
            v_safe = '0;
        end else if (v_control >= VCC_LEVEL) begin
            v_safe = VCC_LEVEL - 16'sd1;  // 32766.
        end else begin
            v_safe = v_control;
        end
        log_num = log_in_t'(v_safe) << LN_FRAC_BITS;
        log_den = log_in_t'(VCC_LEVEL - v_safe) << 1;  // never below 2.
    end

    // log argument, ratio rounded up so any positive voltage moves it off 1.0.
    always_ff @(posedge clk) begin
        if (rst) begin
            to_log_8_shifted <= log_in_t'(LOG_ONE);
        end else begin
            to_log_8_shifted <= log_in_t'(LOG_ONE) + (log_num + log_den - 1'b1) / log_den;
        end
    end

    natural_log i_natural_log (
        .clk           (clk),
        .rst           (rst),
        .in_8_shifted  (to_log_8_shifted),
        .out_8_shifted (ln_8_shifted)
    );

    // high count, multiply then drop the fraction bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            cycles_high <= '0;
        end else begin
            cycles_high <= (C_R1_R2_35_SHIFTED * cycle_count_t'(ln_8_shifted) * CLOCK_RATE)
                           >> HIGH_SHIFT;
        end
    end

    assign wave_length = cycles_high + CYCLES_LOW;  // new period applies at once.

    always_ff @(posedge clk) begin
        if (rst) begin
            wave_counter <= '0;
        end else if (wave_counter < wave_length) begin
            wave_counter <= wave_counter + 1'b1;
        end else begin
            wave_counter <= '0;  // also catches a period that just shrank.
        end
    end

    // output sample follows the enable by one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= audio_clk_en;
        end
    end

    always_ff @(posedge clk) begin
        if (audio_clk_en) begin
            sample_data <= (wave_counter < cycles_high) ? HIGH_LEVEL : LOW_LEVEL;
        end
    end

    // through clamp, log and multiply a positive voltage gives a real high phase.
    assert property (@(posedge clk) disable iff (rst)
        (v_control > 0) |-> ##4 (cycles_high != '0))
        else $error("astable_555_vco zero high count for positive control voltage.");

endmodule

`default_nettype wire

/* design/audio_egress.sv */
// audio output side.
// buffers oscillator samples and sends them downstream one per cycle
// while credits remain. the sink returns credits by single-cycle pulses.
// samples arriving at a full buffer are dropped and counted.
`default_nettype none

module audio_egress #(
    parameter int unsigned OUT_DEPTH   = 8,
    parameter int unsigned OUT_CREDITS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sample_valid,
    input  discrete_pkg::sample_t                sample_data,
    output logic                                 out_valid,
    output discrete_pkg::sample_t                out_data,
    input  logic                                 out_credit,
    output logic [discrete_pkg::DROP_COUNT_W-1:0] drop_count
);
    import discrete_pkg::*;

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    sample_t          mem [OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;  // downstream slots we may still fill.
    logic             full;
    logic             send;
    logic             push;

    assign full = (count == CNT_W'(OUT_DEPTH));
    assign send = (count != '0) && (credits != '0);
    assign push = sample_valid && (!full || send);  // a send frees the slot in time.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit counter.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;  // returned by the sink.
                2'b01:   credits <= credits - 1'b1;  // spent on a send.
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (sample_valid && !push) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // sink returning a credit it never received would push past OUT_CREDITS.
    assert property (@(posedge clk) disable iff (rst)
        (out_credit && !send) |-> (credits < CRD_W'(OUT_CREDITS)))
        else $error("audio_egress credit counter above OUT_CREDITS.");

endmodule

`default_nettype wire

/* design/discrete_555_top.sv */
// discrete 555 voltage-controlled oscillator, top level.
// sets the circuit values and buffer sizes, and connects the control
// voltage input side, the oscillator and the audio output side.
`default_nettype none

module discrete_555_top #(
    parameter int unsigned CLOCK_RATE   = 1000000,  // short periods for simulation.
    parameter int unsigned R1           = 47000,
    parameter int unsigned R2           = 27000,
    parameter int unsigned C_35_SHIFTED = 1134,
    parameter int unsigned CV_DEPTH     = 4,
    parameter int unsigned OUT_DEPTH    = 8,
    parameter int unsigned OUT_CREDITS  = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  audio_clk_en,
    input  logic                                  cv_valid,
    input  discrete_pkg::sample_t                 cv_data,
    output logic                                  cv_credit,
    output logic                                  out_valid,
    output discrete_pkg::sample_t                 out_data,
    input  logic                                  out_credit,
    output logic [discrete_pkg::DROP_COUNT_W-1:0] drop_count
);
    import discrete_pkg::*;

    sample_t v_control;    // held control voltage.
    logic    sample_valid;
    sample_t sample_data;  // square wave sample.

    cv_ingress #(
        .CV_DEPTH (CV_DEPTH)
    ) i_cv_ingress (
        .clk       (clk),
        .rst       (rst),
        .cv_valid  (cv_valid),
        .cv_data   (cv_data),
        .cv_credit (cv_credit),
        .v_control (v_control)
    );

    astable_555_vco #(
        .CLOCK_RATE   (CLOCK_RATE),
        .R1           (R1),
        .R2           (R2),
        .C_35_SHIFTED (C_35_SHIFTED)
    ) i_astable_555_vco (
        .clk          (clk),
        .rst          (rst),
        .audio_clk_en (audio_clk_en),
        .v_control    (v_control),
        .sample_valid (sample_valid),
        .sample_data  (sample_data)
    );

    audio_egress #(
        .OUT_DEPTH   (OUT_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_audio_egress (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_credit   (out_credit),
        .drop_count   (drop_count)
    );

endmodule

`default_nettype wire

/* test/discrete_555_tb.sv */
// testbench for the discrete 555 voltage-controlled oscillator.
// reads one test per line from the tests file, sends the control voltage
// under the input credit rule, then measures high and low run lengths
// of the output square wave and exercises output back-pressure.
`default_nettype none

module discrete_555_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import discrete_pkg::*;

    localparam int CV_DEPTH     = 4;   // top level defaults.
    localparam int OUT_CREDITS  = 4;
    localparam int DRAIN_CYCLES = 32;  // enable off while the buffer empties.
    localparam int CV_COPIES    = 3;   // samples sent per test.

    logic                    clk;
    logic                    rst;
    logic                    audio_clk_en;
    logic                    cv_valid;
    sample_t                 cv_data;
    logic                    cv_credit;
    logic                    out_valid;
    sample_t                 out_data;
    logic                    out_credit;
    logic [DROP_COUNT_W-1:0] drop_count;

    // test table.
    int t_cv[$];
    int t_settle[$];
    int t_high[$];
    int t_low[$];
    int t_hold[$];

    int     mismatch_errors = 0;
    int     other_errors    = 0;
    bit     tests_loaded    = 0;
    longint limit_ns        = 0;

    // sink and source state.
    int  cv_credits    = CV_DEPTH;  // source side credit count.
    int  sent          = 0;
    int  credit_pulses = 0;
    int  owed          = 0;         // credits the sink still has to return.
    bit  withholding   = 0;
    int  hold_beats    = 0;
    bit  en_on         = 0;
    int  enabled       = 0;
    int  received      = 0;

    // run length tracker.
    bit      tracking  = 0;
    bit      have_prev = 0;
    bit      from_edge = 0;  // current run began on a seen transition.
    sample_t prev;
    int      run_len;
    int      high_runs[$];
    int      low_runs[$];

    discrete_555_top i_discrete_555_top (
        .clk          (clk),
        .rst          (rst),
        .audio_clk_en (audio_clk_en),
        .cv_valid     (cv_valid),
        .cv_data      (cv_data),
        .cv_credit    (cv_credit),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_credit   (out_credit),
        .drop_count   (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    task automatic check_sample(input string name, input sample_t expected,
                                input sample_t actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input longint expected,
                               input longint actual, input int tol);
        longint diff;
        diff = actual - expected;
        if (diff < -tol || diff > tol) begin
            mismatch_errors++;
            $display("MISMATCH time %0t %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic read_tests();
        int    fd;
        string line;
        int    n;
        int    cv, st, hi, lo, wh;
        fd = $fopen("test/vco_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the test file test/vco_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;  // comment or empty.
            end
            n = $sscanf(line, "%d %d %d %d %d", cv, st, hi, lo, wh);
            if (n == 5) begin
                t_cv.push_back(cv);
                t_settle.push_back(st);
                t_high.push_back(hi);
                t_low.push_back(lo);
                t_hold.push_back(wh);
            end
        end
        $fclose(fd);
    endtask

    // records a run once the value changes; the first run is partial.
    task automatic track_run(input sample_t s);
        if (!have_prev) begin
            prev      = s;
            run_len   = 1;
            have_prev = 1;
            from_edge = 0;
        end else if (s == prev) begin
            run_len++;
        end else begin
            if (from_edge) begin
                if (prev == HIGH_LEVEL) high_runs.push_back(run_len);
                else low_runs.push_back(run_len);
            end
            prev      = s;
            run_len   = 1;
            from_edge = 1;
        end
    endtask

    // outputs are sampled at the falling edge half a cycle after they change.
    task automatic observe();
        if (cv_credit === 1'b1) begin
            cv_credits++;
            credit_pulses++;
            if (cv_credits > CV_DEPTH) begin
                other_errors++;
                $display("cv_credit pulse at %0t with no sample outstanding", $time);
            end
        end
        if (out_valid === 1'b1) begin
            received++;
            owed++;
            if (withholding) hold_beats++;
            if (out_data !== HIGH_LEVEL) check_sample("out_data", LOW_LEVEL, out_data);
            if (tracking) track_run(out_data);
        end
    endtask

    // one clock step that reads the outputs and drives the inputs for the next edge.
    task automatic step(input logic v, input sample_t d);
        @(negedge clk);
        observe();
        cv_valid     = v;
        cv_data      = d;
        audio_clk_en = en_on;
        if (!withholding && owed > 0) begin
            out_credit = 1'b1;  // one credit back per cycle.
            owed--;
        end else begin
            out_credit = 1'b0;
        end
        if (en_on) enabled++;
    endtask

    task automatic send_cv(input sample_t v);
        while (cv_credits == 0) step(1'b0, '0);  // no sample without a credit.
        step(1'b1, v);
        cv_credits--;
        sent++;
    endtask

    task automatic run_test(input int i);
        logic [DROP_COUNT_W-1:0] drop_start;
        logic [DROP_COUNT_W-1:0] drops;
        enabled       = 0;
        received      = 0;
        sent          = 0;
        credit_pulses = 0;
        drop_start    = drop_count;
        en_on         = 1;
        repeat (CV_COPIES) send_cv(sample_t'(t_cv[i]));
        repeat (t_settle[i]) step(1'b0, '0);

        // wait for one whole high run and one whole low run.
        high_runs.delete();
        low_runs.delete();
        have_prev = 0;
        tracking  = 1;
        while (high_runs.size() == 0 || low_runs.size() == 0) step(1'b0, '0);
        tracking = 0;
        check_count($sformatf("high run length, test %0d", i), t_high[i], high_runs[0], 1);
        check_count($sformatf("low run length, test %0d", i), t_low[i], low_runs[0], 1);
        check_count("drop_count before withhold", drop_start, drop_count, 0);

        if (t_hold[i] > 0) begin
            withholding = 1;
            hold_beats  = 0;
            repeat (t_hold[i]) step(1'b0, '0);
            if (hold_beats > OUT_CREDITS) begin
                other_errors++;
                $display("out_valid went on past the credit limit in test %0d", i);
            end
            if (t_hold[i] > OUT_CREDITS + 2 && out_valid === 1'b1) begin
                other_errors++;
                $display("out_valid still high at the end of the withhold in test %0d", i);
            end
            withholding = 0;
        end

        en_on = 0;
        repeat (DRAIN_CYCLES) step(1'b0, '0);
        drops = drop_count - drop_start;
        check_count("samples received plus dropped", enabled, received + drops, 0);
        check_count("cv_credit pulses", sent, credit_pulses, 0);
        check_count("input credits held", CV_DEPTH, cv_credits, 0);
    endtask

    initial begin
        longint cycles;
        rst          = 1'b1;
        audio_clk_en = 1'b0;
        cv_valid     = 1'b0;
        cv_data      = '0;
        out_credit   = 1'b0;

        read_tests();
        if (t_cv.size() == 0) begin
            other_errors++;
            $display("no tests were read from the test file");
        end
        cycles = 2000;  // reset and margin.
        foreach (t_cv[i]) begin
            cycles += t_settle[i] + 4 * (t_high[i] + t_low[i] + 1) + t_hold[i]
                      + DRAIN_CYCLES + 4 * CV_COPIES;
        end
        limit_ns     = cycles * 8;
        tests_loaded = 1;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_count("cv_credit after reset", 0, cv_credit, 0);
        check_count("out_valid after reset", 0, out_valid, 0);
        check_count("drop_count after reset", 0, drop_count, 0);
        step(1'b0, '0);
        check_count("out_valid after reset", 0, out_valid, 0);

        foreach (t_cv[i]) begin
            run_test(i);
        end

        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog sized from the test table.
    initial begin
        wait (tests_loaded);
        #(limit_ns);
        $display("watchdog timeout, run went past %0d ns", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/vco_tests.txt */
# columns: control voltage, settle cycles, expected high run length,
#          expected low run length, credit withhold cycles (0 = none)
16384 20 1001 618 0
4096 20 181 618 6
8192 24 381 618 20
24576 20 2232 618 0
30000 20 4541 618 40
4096 16 181 618 0
16384 20 1001 618 12
8192 20 381 618 0
24576 30 2232 618 8
4096 20 181 618 30
30000 20 4541 618 0
8192 16 381 618 4
16384 20 1001 618 60

/* build.f */
design/discrete_pkg.sv
design/natural_log.sv
design/cv_ingress.sv
design/astable_555_vco.sv
design/audio_egress.sv
design/discrete_555_top.sv
test/discrete_555_tb.sv

/* Bender.yml */
package:
  name: discrete_555

sources:
  - design/discrete_pkg.sv
  - design/natural_log.sv
  - design/cv_ingress.sv
  - design/astable_555_vco.sv
  - design/audio_egress.sv
  - design/discrete_555_top.sv
  - target: test
    files:
      - test/discrete_555_tb.sv
